// ==== verilog/fcvt_pkg.sv ====
package fcvt_pkg;

  // operand and result width
  localparam int data_w = 32;

  // enabled cycles through each pipeline
  localparam int f2i_latency = 5;
  localparam int i2f_latency = 9;

  // latency down-counter, wide enough for i2f_latency
  localparam int cnt_w = 4;

  // single-precision field layout
  localparam int exp_bias = 127;
  localparam int exp_w    = 8;
  localparam int man_w    = 23;

  // signed 32-bit saturation limits
  localparam logic [data_w-1:0] int_max = 32'h7fff_ffff;
  localparam logic [data_w-1:0] int_min = 32'h8000_0000;

  typedef enum logic {
    mode_f2i = 1'b0,  // float to signed integer
    mode_i2f = 1'b1   // signed integer to float
  } mode_t;

  typedef enum logic [1:0] {
    st_idle,
    st_f2i,
    st_i2f
  } state_t;

endpackage

// ==== verilog/f2i_pipe.sv ====
`timescale 1ns/1ps

module f2i_pipe (
  input  logic                        clk,
  input  logic                        rst,
  input  logic                        en,
  input  logic [fcvt_pkg::data_w-1:0] a,
  output logic [fcvt_pkg::data_w-1:0] q
);

  logic                                     s1_sign;
  logic [fcvt_pkg::exp_w-1:0]               s1_exp;
  logic [fcvt_pkg::man_w-1:0]               s1_man;
  logic                                     s1_nan;
  logic                                     s1_inf;
  logic                                     s1_big;
  logic                                     s2_sign;
  logic                                     s2_sat_pos;
  logic                                     s2_sat_neg;
  logic                                     s2_zero;
  logic [4:0]                               s2_shamt;
  logic [fcvt_pkg::man_w:0]                 s2_man;
  logic                                     s3_sign;
  logic                                     s3_sat_pos;
  logic                                     s3_sat_neg;
  logic                                     s3_zero;
  logic [fcvt_pkg::man_w+fcvt_pkg::data_w-1:0] s3_wide;
  logic [fcvt_pkg::man_w+fcvt_pkg::data_w-1:0] s3_shifted;
  logic [2:0]                               s3_fine;
  logic                                     s4_sign;
  logic                                     s4_sat_pos;
  logic                                     s4_sat_neg;
  logic                                     s4_zero;
  logic [fcvt_pkg::data_w-1:0]              s4_mag;

  // |a| >= 2^31 once the exponent reaches bias + 31
  assign s1_big = s1_exp >= fcvt_pkg::exp_bias + fcvt_pkg::data_w - 1;

  assign s3_shifted = s3_wide << s3_fine;  // fine step of the barrel shift

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      s1_sign    <= 1'b0;
      s1_nan     <= 1'b0;
      s1_inf     <= 1'b0;
      s2_sign    <= 1'b0;
      s2_sat_pos <= 1'b0;
      s2_sat_neg <= 1'b0;
      s2_zero    <= 1'b0;
      s3_sign    <= 1'b0;
      s3_sat_pos <= 1'b0;
      s3_sat_neg <= 1'b0;
      s3_zero    <= 1'b0;
      s4_sign    <= 1'b0;
      s4_sat_pos <= 1'b0;
      s4_sat_neg <= 1'b0;
      s4_zero    <= 1'b0;
    end else if (en) begin
      s1_sign    <= a[fcvt_pkg::data_w-1];
      s1_inf     <= (&a[fcvt_pkg::data_w-2 -: fcvt_pkg::exp_w]) &&
                    !(|a[fcvt_pkg::man_w-1:0]);
      s1_nan     <= (&a[fcvt_pkg::data_w-2 -: fcvt_pkg::exp_w]) &&
                    (|a[fcvt_pkg::man_w-1:0]);
      s2_sign    <= s1_sign;
      s2_sat_pos <= s1_nan || (!s1_sign && (s1_inf || s1_big));  // nan goes positive
      s2_sat_neg <= !s1_nan && s1_sign && (s1_inf || s1_big);
      s2_zero    <= s1_exp < fcvt_pkg::exp_bias;  // denormals and |a| < 1
      s3_sign    <= s2_sign;
      s3_sat_pos <= s2_sat_pos;
      s3_sat_neg <= s2_sat_neg;
      s3_zero    <= s2_zero;
      s4_sign    <= s3_sign;
      s4_sat_pos <= s3_sat_pos;
      s4_sat_neg <= s3_sat_neg;
      s4_zero    <= s3_zero;
    end
  end

  always_ff @(posedge clk) begin
    if (en) begin
      s1_exp   <= a[fcvt_pkg::data_w-2 -: fcvt_pkg::exp_w];
      s1_man   <= a[fcvt_pkg::man_w-1:0];
      s2_shamt <= 5'(s1_exp - fcvt_pkg::exp_bias);  // unbiased exponent, 0..30 when used
      s2_man   <= {1'b1, s1_man};  // restore hidden one
      // coarse step, multiples of eight
      s3_wide  <= {{(fcvt_pkg::data_w-1){1'b0}}, s2_man} << {s2_shamt[4:3], 3'b000};
      s3_fine  <= s2_shamt[2:0];
      s4_mag   <= s3_shifted[fcvt_pkg::man_w+fcvt_pkg::data_w-1:fcvt_pkg::man_w];
      if (s4_sat_pos) begin
        q <= fcvt_pkg::int_max;
      end else if (s4_sat_neg) begin
        q <= fcvt_pkg::int_min;
      end else if (s4_zero) begin
        q <= '0;
      end else begin
        q <= s4_sign ? -s4_mag : s4_mag;  // truncation toward zero
      end
    end
  end

endmodule

// ==== verilog/i2f_pipe.sv ====
`timescale 1ns/1ps

module i2f_pipe (
  input  logic                        clk,
  input  logic                        rst,
  input  logic                        en,
  input  logic [fcvt_pkg::data_w-1:0] a,
  output logic [fcvt_pkg::data_w-1:0] q
);

  logic                        s1_sign;
  logic [fcvt_pkg::data_w-1:0] s1_inv;
  logic                        s2_sign;
  logic [fcvt_pkg::data_w-1:0] s2_mag;
  logic                        s3_sign;
  logic [fcvt_pkg::data_w-1:0] s3_mag;
  logic [3:0][3:0]             s3_seg_lz;
  logic                        s4_sign;
  logic [fcvt_pkg::data_w-1:0] s4_mag;
  logic [1:0][4:0]             s4_half_lz;
  logic                        s5_sign;
  logic [fcvt_pkg::data_w-1:0] s5_mag;
  logic [5:0]                  s5_lz;
  logic                        s6_sign;
  logic                        s6_zero;
  logic [fcvt_pkg::data_w-1:0] s6_mag;
  logic [2:0]                  s6_fine;
  logic [fcvt_pkg::exp_w-1:0]  s6_exp;
  logic                        s7_sign;
  logic                        s7_zero;
  logic [fcvt_pkg::data_w-1:0] s7_norm;
  logic [fcvt_pkg::exp_w-1:0]  s7_exp;
  logic [fcvt_pkg::man_w-1:0]  s7_man;
  logic                        s7_guard;
  logic                        s7_rnd;
  logic                        s7_sticky;
  logic                        s7_up;
  logic                        s8_sign;
  logic                        s8_zero;
  logic [fcvt_pkg::exp_w-1:0]  s8_exp;
  logic [fcvt_pkg::man_w:0]    s8_sum;

  // leading zeros of one byte, 8 when empty
  function automatic logic [3:0] lz8(input logic [7:0] v);
    logic [3:0] n;
    n = 4'd8;
    for (int i = 0; i < 8; i++) begin
      if (v[i]) n = 4'(7 - i);  // highest set bit wins
    end
    return n;
  endfunction

  // bit 31 of s7_norm is the hidden one
  assign s7_man    = s7_norm[fcvt_pkg::data_w-2 -: fcvt_pkg::man_w];
  assign s7_guard  = s7_norm[fcvt_pkg::data_w-2-fcvt_pkg::man_w];
  assign s7_rnd    = s7_norm[fcvt_pkg::data_w-3-fcvt_pkg::man_w];
  assign s7_sticky = |s7_norm[fcvt_pkg::data_w-4-fcvt_pkg::man_w:0];
  assign s7_up     = s7_guard && (s7_rnd || s7_sticky || s7_man[0]);  // ties to even

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      s1_sign <= 1'b0;
      s2_sign <= 1'b0;
      s3_sign <= 1'b0;
      s4_sign <= 1'b0;
      s5_sign <= 1'b0;
      s6_sign <= 1'b0;
      s7_sign <= 1'b0;
      s8_sign <= 1'b0;
      s6_zero <= 1'b0;
      s7_zero <= 1'b0;
      s8_zero <= 1'b0;
    end else if (en) begin
      s1_sign <= a[fcvt_pkg::data_w-1];
      s2_sign <= s1_sign;
      s3_sign <= s2_sign;
      s4_sign <= s3_sign;
      s5_sign <= s4_sign;
      s6_sign <= s5_sign;
      s7_sign <= s6_sign;
      s8_sign <= s7_sign;
      s6_zero <= s5_lz[5];  // only a zero input has 32 leading zeros
      s7_zero <= s6_zero;
      s8_zero <= s7_zero;
    end
  end

  always_ff @(posedge clk) begin
    if (en) begin
      s1_inv <= a ^ {fcvt_pkg::data_w{a[fcvt_pkg::data_w-1]}};
      s2_mag <= s1_inv + {{(fcvt_pkg::data_w-1){1'b0}}, s1_sign};  // int_min stays 2^31
      s3_mag <= s2_mag;
      for (int i = 0; i < 4; i++) begin
        s3_seg_lz[i] <= lz8(s2_mag[8*i +: 8]);
      end
      s4_mag <= s3_mag;
      s4_half_lz[1] <= s3_seg_lz[3][3] ? 5'd8 + {1'b0, s3_seg_lz[2]} : {1'b0, s3_seg_lz[3]};
      s4_half_lz[0] <= s3_seg_lz[1][3] ? 5'd8 + {1'b0, s3_seg_lz[0]} : {1'b0, s3_seg_lz[1]};
      s5_mag <= s4_mag;
      s5_lz  <= s4_half_lz[1][4] ? 6'd16 + {1'b0, s4_half_lz[0]} : {1'b0, s4_half_lz[1]};
      s6_mag  <= s5_mag << {s5_lz[4:3], 3'b000};  // byte step
      s6_fine <= s5_lz[2:0];
      s6_exp  <= 8'(fcvt_pkg::exp_bias + fcvt_pkg::data_w - 1 - s5_lz);
      s7_norm <= s6_mag << s6_fine;  // bit step
      s7_exp  <= s6_exp;
      s8_exp  <= s7_exp;
      s8_sum  <= {1'b0, s7_man} + s7_up;
      if (s8_zero) begin
        q <= '0;  // +0.0
      end else begin
        // a carry out of the mantissa leaves zeros below it
        q <= {s8_sign, s8_exp + s8_sum[fcvt_pkg::man_w], s8_sum[fcvt_pkg::man_w-1:0]};
      end
    end
  end

endmodule

// ==== verilog/fcvt_ctrl.sv ====
`timescale 1ns/1ps

module fcvt_ctrl (
  input  logic                        clk,
  input  logic                        rst,
  input  logic                        en,
  input  fcvt_pkg::mode_t             mode,
  input  logic [fcvt_pkg::data_w-1:0] data_in,
  input  logic [fcvt_pkg::data_w-1:0] f2i_q,
  input  logic [fcvt_pkg::data_w-1:0] i2f_q,
  output logic [fcvt_pkg::data_w-1:0] operand,
  output logic                        f2i_en,
  output logic                        i2f_en,
  output logic                        done,
  output logic [fcvt_pkg::data_w-1:0] data_out
);

  fcvt_pkg::state_t            state;
  fcvt_pkg::state_t            nxt_state;
  logic [fcvt_pkg::cnt_w-1:0]  cnt;
  logic [fcvt_pkg::cnt_w-1:0]  cnt_nxt;
  logic                        done_nxt;
  logic [fcvt_pkg::data_w-1:0] data_out_nxt;
  logic [fcvt_pkg::data_w-1:0] operand_nxt;

  // pipe advances while enabled cycles remain
  assign f2i_en = (state == fcvt_pkg::st_f2i) && (cnt != '0);
  assign i2f_en = (state == fcvt_pkg::st_i2f) && (cnt != '0);

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      state    <= fcvt_pkg::st_idle;
      cnt      <= '0;
      done     <= 1'b0;
      data_out <= '0;
      operand  <= '0;
    end else begin
      state    <= nxt_state;
      cnt      <= cnt_nxt;
      done     <= done_nxt;
      data_out <= data_out_nxt;
      operand  <= operand_nxt;
    end
  end

  always_comb begin
    nxt_state    = state;
    cnt_nxt      = cnt;
    done_nxt     = 1'b0;
    data_out_nxt = data_out;  // held until the next result
    operand_nxt  = operand;
    case (state)
      fcvt_pkg::st_idle: begin
        if (en) begin
          operand_nxt = data_in;  // stable input for the whole run
          if (mode == fcvt_pkg::mode_f2i) begin
            nxt_state = fcvt_pkg::st_f2i;
            cnt_nxt   = fcvt_pkg::f2i_latency[fcvt_pkg::cnt_w-1:0];
          end else begin
            nxt_state = fcvt_pkg::st_i2f;
            cnt_nxt   = fcvt_pkg::i2f_latency[fcvt_pkg::cnt_w-1:0];
          end
        end
      end
      fcvt_pkg::st_f2i: begin
        if (cnt != '0) begin
          cnt_nxt = cnt - 1'b1;
        end else begin
          data_out_nxt = f2i_q;
          done_nxt     = 1'b1;
          nxt_state    = fcvt_pkg::st_idle;
        end
      end
      fcvt_pkg::st_i2f: begin
        if (cnt != '0) begin
          cnt_nxt = cnt - 1'b1;
        end else begin
          data_out_nxt = i2f_q;
          done_nxt     = 1'b1;
          nxt_state    = fcvt_pkg::st_idle;
        end
      end
      default: begin
        nxt_state = fcvt_pkg::st_idle;  // unused encoding
      end
    endcase
  end

endmodule

// ==== verilog/fcvt_top.sv ====
`timescale 1ns/1ps

module fcvt_top (
  input  logic                        clk,
  input  logic                        rst,
  input  logic                        en,
  input  fcvt_pkg::mode_t             mode,
  input  logic [fcvt_pkg::data_w-1:0] data_in,
  output logic                        done,
  output logic [fcvt_pkg::data_w-1:0] data_out
);

  logic [fcvt_pkg::data_w-1:0] operand;
  logic                        f2i_en;
  logic                        i2f_en;
  logic [fcvt_pkg::data_w-1:0] f2i_q;
  logic [fcvt_pkg::data_w-1:0] i2f_q;

  fcvt_ctrl ctrl_i (
    .clk      (clk),
    .rst      (rst),
    .en       (en),
    .mode     (mode),
    .data_in  (data_in),
    .f2i_q    (f2i_q),
    .i2f_q    (i2f_q),
    .operand  (operand),
    .f2i_en   (f2i_en),
    .i2f_en   (i2f_en),
    .done     (done),
    .data_out (data_out)
  );

  f2i_pipe f2i_i (
    .clk (clk),
    .rst (rst),
    .en  (f2i_en),
    .a   (operand),  // both pipes share the latched operand
    .q   (f2i_q)
  );

  i2f_pipe i2f_i (
    .clk (clk),
    .rst (rst),
    .en  (i2f_en),
    .a   (operand),
    .q   (i2f_q)
  );

endmodule

// ==== verif/fcvt_tb.sv ====
`timescale 1ns/1ps

module fcvt_tb;

  localparam int done_timeout = 20;  // cycles allowed for one done pulse

  logic                        clk;
  logic                        rst;
  logic                        en;
  fcvt_pkg::mode_t             mode;
  logic [fcvt_pkg::data_w-1:0] data_in;
  logic                        done;
  logic [fcvt_pkg::data_w-1:0] data_out;

  int n_pass;
  int n_fail;
  int seed_val;

  fcvt_top dut_i (
    .clk      (clk),
    .rst      (rst),
    .en       (en),
    .mode     (mode),
    .data_in  (data_in),
    .done     (done),
    .data_out (data_out)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // truncate toward zero, saturate out of range, nan and inf
  function automatic logic [31:0] f2i_model(input logic [31:0] f);
    logic        sign;
    int          e;
    logic [63:0] mag;
    sign = f[31];
    e    = int'(f[30:23]);
    if (e == 255 && f[22:0] != 0) return fcvt_pkg::int_max;
    if (e >= fcvt_pkg::exp_bias + 31) return sign ? fcvt_pkg::int_min : fcvt_pkg::int_max;
    if (e < fcvt_pkg::exp_bias) return '0;
    mag = {40'd0, 1'b1, f[22:0]};
    if (e - fcvt_pkg::exp_bias >= 23) begin
      mag = mag << (e - fcvt_pkg::exp_bias - 23);
    end else begin
      mag = mag >> (fcvt_pkg::exp_bias + 23 - e);
    end
    return sign ? -mag[31:0] : mag[31:0];
  endfunction

  // signed integer to single, nearest even
  function automatic logic [31:0] i2f_model(input logic [31:0] v);
    logic        sign;
    logic [31:0] mag;
    int          p;
    int          s;
    logic [7:0]  e;
    logic [63:0] kept;
    logic [63:0] rem;
    logic [63:0] half;
    if (v == '0) return '0;
    sign = v[31];
    mag  = sign ? (~v + 32'd1) : v;
    p    = 0;
    for (int i = 0; i < 32; i++) begin
      if (mag[i]) p = i;  // position of the leading one
    end
    e = 8'(fcvt_pkg::exp_bias + p);
    if (p <= 23) begin
      kept = 64'(mag) << (23 - p);
    end else begin
      s    = p - 23;
      kept = 64'(mag) >> s;
      rem  = 64'(mag) & ((64'd1 << s) - 64'd1);
      half = 64'd1 << (s - 1);
      if (rem > half || (rem == half && kept[0])) kept = kept + 64'd1;
      if (kept[24]) begin
        kept = kept >> 1;  // rounding carried into a new bit
        e    = e + 8'd1;
      end
    end
    return {sign, e, kept[22:0]};
  endfunction

  function automatic logic [31:0] model(input fcvt_pkg::mode_t m, input logic [31:0] v);
    return (m == fcvt_pkg::mode_f2i) ? f2i_model(v) : i2f_model(v);
  endfunction

  task automatic check_word(input string name, input logic [fcvt_pkg::data_w-1:0] expected,
                            input logic [fcvt_pkg::data_w-1:0] actual);
    if (actual === expected) begin
      n_pass++;
    end else begin
      n_fail++;
      $display("ERROR %s: expected %h, actual %h", name, expected, actual);
    end
  endtask

  task automatic check_mode_latency(input fcvt_pkg::mode_t m, input int expected,
                                    input int measured);
    if (measured == expected) begin
      n_pass++;
    end else begin
      n_fail++;
      $display("ERROR latency %s: expected %0d, actual %0d", m.name(), expected, measured);
    end
  endtask

  // returns right after the edge that samples en
  task automatic start_op(input fcvt_pkg::mode_t m, input logic [31:0] v);
    @(posedge clk);
    en      <= 1'b1;
    mode    <= m;
    data_in <= v;
    @(posedge clk);
    en      <= 1'b0;
  endtask

  task automatic wait_done(output int cycles, output bit ok);
    cycles = 0;
    ok     = 1'b0;
    while (!ok && cycles < done_timeout) begin
      @(negedge clk);  // outputs settled mid-cycle
      if (done) ok = 1'b1;
      else cycles++;  // edges counted from the sampling edge
    end
    if (!ok) begin
      n_fail++;
      $display("no done pulse within %0d cycles", done_timeout);
    end
  endtask

  task automatic run_op(input fcvt_pkg::mode_t m, input logic [31:0] v,
                        output logic [31:0] result, output int cycles, output bit ok);
    start_op(m, v);
    wait_done(cycles, ok);
    result = data_out;
  endtask

  task automatic report_test(input string name, input int fails_before);
    if (n_fail == fails_before) $display("%s: ok", name);
    else $display("%s: %0d errors", name, n_fail - fails_before);
  endtask

  task automatic reset_state();
    int fails_before;
    fails_before = n_fail;
    repeat (5) begin
      @(negedge clk);
      if (done) begin
        n_fail++;
        $display("done went high after reset with en low");
      end
      check_word("reset data_out", '0, data_out);
    end
    report_test("reset state", fails_before);
  endtask

  task automatic run_directed(input string name, input fcvt_pkg::mode_t m,
                              input logic [31:0] vals[], input int latency);
    int          fails_before;
    int          cycles;
    bit          ok;
    logic [31:0] result;
    fails_before = n_fail;
    foreach (vals[i]) begin
      run_op(m, vals[i], result, cycles, ok);
      if (ok) begin
        check_word($sformatf("%s %h", name, vals[i]), model(m, vals[i]), result);
        check_mode_latency(m, latency, cycles);
      end
    end
    report_test(name, fails_before);
  endtask

  task automatic random_mix();
    int              fails_before;
    int              cycles;
    bit              ok;
    logic [31:0]     v;
    logic [31:0]     result;
    fcvt_pkg::mode_t m;
    fails_before = n_fail;
    for (int i = 0; i < 200; i++) begin
      m = ($urandom & 1) ? fcvt_pkg::mode_i2f : fcvt_pkg::mode_f2i;
      v = $urandom;
      if (m == fcvt_pkg::mode_f2i && ($urandom & 1)) begin
        v[30:23] = 8'(112 + $urandom % 48);  // mostly finite integers in range
      end
      run_op(m, v, result, cycles, ok);
      if (ok) begin
        check_word($sformatf("random %s %h", m.name(), v), model(m, v), result);
        @(negedge clk);
        check_word("random hold", result, data_out);
      end
      repeat ($urandom % 3) @(posedge clk);
    end
    report_test("random mix", fails_before);
  endtask

  task automatic start_while_busy();
    int          fails_before;
    int          cycles;
    bit          ok;
    logic [31:0] first;
    first        = 32'h0123_4567;
    fails_before = n_fail;
    start_op(fcvt_pkg::mode_i2f, first);
    repeat (3) @(posedge clk);
    en      <= 1'b1;  // second start lands mid-run
    mode    <= fcvt_pkg::mode_f2i;
    data_in <= 32'h3f80_0000;
    @(posedge clk);
    en      <= 1'b0;
    wait_done(cycles, ok);
    if (ok) begin
      check_word("busy first result", i2f_model(first), data_out);
      for (int i = 0; i < done_timeout; i++) begin
        @(negedge clk);
        if (done) begin
          n_fail++;
          $display("a second done pulse followed the dropped start");
        end
      end
    end
    report_test("start while busy", fails_before);
  endtask

  initial begin
    n_pass   = 0;
    n_fail   = 0;
    seed_val = $urandom(73990);
    rst      = 1'b1;
    en       = 1'b0;
    mode     = fcvt_pkg::mode_f2i;
    data_in  = '0;
    repeat (4) @(posedge clk);
    rst <= 1'b0;

    reset_state();
    // 1.0, -2.5, 0.75, 2^30, 3e9, -3e9, +inf, -inf, nan
    run_directed("float to int", fcvt_pkg::mode_f2i,
                 '{32'h3f80_0000, 32'hc020_0000, 32'h3f40_0000, 32'h4e80_0000, 32'h4f32_d05e,
                   32'hcf32_d05e, 32'h7f80_0000, 32'hff80_0000, 32'h7fc0_0000},
                 fcvt_pkg::f2i_latency + 1);
    run_directed("int to float", fcvt_pkg::mode_i2f,
                 '{32'd0, 32'd1, 32'hffff_ffff, fcvt_pkg::int_max, fcvt_pkg::int_min,
                   32'd16777217},
                 fcvt_pkg::i2f_latency + 1);
    random_mix();
    start_while_busy();

    $display("checks passed: %0d, failed: %0d", n_pass, n_fail);
    if (n_fail == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule

// ==== fcvt_top.f ====
verilog/fcvt_pkg.sv
verilog/f2i_pipe.sv
verilog/i2f_pipe.sv
verilog/fcvt_ctrl.sv
verilog/fcvt_top.sv
verif/fcvt_tb.sv

// ==== Bender.yml ====
package:
  name: fcvt

sources:
  - files:
      - verilog/fcvt_pkg.sv
      - verilog/f2i_pipe.sv
      - verilog/i2f_pipe.sv
      - verilog/fcvt_ctrl.sv
      - verilog/fcvt_top.sv

  - target: test
    files:
      - verif/fcvt_tb.sv
